//--- Bender.yml
package:
  name: afifo

sources:
  # synthesizable design, package first
  - hw/afifo_pkg.sv
  - hw/afifo_ram_if.sv
  - hw/afifo_dpram.sv
  - hw/afifo_wr_ctrl.sv
  - hw/afifo_rd_ctrl.sv
  - hw/afifo_top.sv

  # verification only
  - target: test
    files:
      - bench/afifo_properties.sv
      - bench/afifo_tb.sv

//--- afifo.f
hw/afifo_pkg.sv
hw/afifo_ram_if.sv
hw/afifo_dpram.sv
hw/afifo_wr_ctrl.sv
hw/afifo_rd_ctrl.sv
hw/afifo_top.sv
bench/afifo_properties.sv
bench/afifo_tb.sv

//--- bench/afifo_properties.sv
module afifo_properties (
	input logic                         wclk,
	input logic                         wrstn,
	input logic                         rclk,
	input logic                         rrstn,
	input logic                         rinc,
	input logic                         wfull,
	input logic [afifo_pkg::PTR_W-1:0]  wr_level,
	input logic                         rempty,
	input logic [afifo_pkg::PTR_W-1:0]  rd_level,
	input logic [afifo_pkg::DATA_W-1:0] rdata
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// ******************************
	// flags against levels
	// ******************************

	full_level: assert property (@(posedge wclk) disable iff (!wrstn)
		wfull == (wr_level == afifo_pkg::FIFO_DEPTH))
		else begin
			$error("wfull does not match wr_level");
			fail_count++;
		end

	empty_level: assert property (@(posedge rclk) disable iff (!rrstn)
		rempty == (rd_level == 0))
		else begin
			$error("rempty does not match rd_level");
			fail_count++;
		end

	wr_level_range: assert property (@(posedge wclk) disable iff (!wrstn)
		wr_level <= afifo_pkg::FIFO_DEPTH)
		else begin
			$error("wr_level above the depth");
			fail_count++;
		end

	rd_level_range: assert property (@(posedge rclk) disable iff (!rrstn)
		rd_level <= afifo_pkg::FIFO_DEPTH)
		else begin
			$error("rd_level above the depth");
			fail_count++;
		end

	// ******************************
	// read data
	// ******************************

	// without an accepted read the output register holds
	rdata_hold: assert property (@(posedge rclk) disable iff (!rrstn)
		!(rinc && !rempty) |=> $stable(rdata))
		else begin
			$error("rdata changed without an accepted read");
			fail_count++;
		end

endmodule

bind afifo_top afifo_properties u_properties (
	.wclk     (wclk),
	.wrstn    (wrstn),
	.rclk     (rclk),
	.rrstn    (rrstn),
	.rinc     (rinc),
	.wfull    (wfull),
	.wr_level (wr_level),
	.rempty   (rempty),
	.rd_level (rd_level),
	.rdata    (rdata)
);

//--- bench/afifo_tb.sv
module afifo_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          WCLK_HALF   = 7;
	localparam int          RCLK_HALF   = 5;
	localparam logic [31:0] SEED        = 32'd58881;
	localparam int          WAIT_LIMIT  = 60;   // cycles for any single flag wait
	localparam int          DRAIN_LIMIT = 200;
	localparam int          TRAFFIC_LEN = 300;

	logic                         wclk;
	logic                         wrstn;
	logic                         winc;
	logic [afifo_pkg::DATA_W-1:0] wdata;
	logic                         rclk;
	logic                         rrstn;
	logic                         rinc;
	logic                         wfull;
	logic [afifo_pkg::PTR_W-1:0]  wr_level;
	logic                         rempty;
	logic [afifo_pkg::PTR_W-1:0]  rd_level;
	logic [afifo_pkg::DATA_W-1:0] rdata;

	logic [afifo_pkg::DATA_W-1:0] model [$];
	logic [afifo_pkg::DATA_W-1:0] last_read;
	logic [31:0]                  wr_state;
	logic [31:0]                  rd_state;
	bit                           check_pending;
	int                           errors;
	int                           checks;
	int                           tests_run;
	int                           writes_seen;
	int                           reads_seen;

	afifo_top DUT (
		.wclk     (wclk),
		.wrstn    (wrstn),
		.winc     (winc),
		.wdata    (wdata),
		.rclk     (rclk),
		.rrstn    (rrstn),
		.rinc     (rinc),
		.wfull    (wfull),
		.wr_level (wr_level),
		.rempty   (rempty),
		.rd_level (rd_level),
		.rdata    (rdata)
	);

	always #WCLK_HALF wclk = ~wclk;
	always #RCLK_HALF rclk = ~rclk; // 10 ns against 14 ns so the edges drift

	// ******************************
	// helpers
	// ******************************

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic report_test(input string name);
		tests_run++;
		$display("test %s finished, %0d errors so far", name, errors);
	endtask

	// ******************************
	// reference model
	// ******************************

	// a write counts when winc meets a low wfull at the edge
	always @(posedge wclk) begin
		if (wrstn && winc && !wfull) begin
			model.push_back(wdata);
			writes_seen++;
		end
	end

	// the popped word must show on rdata one rclk later
	always @(posedge rclk) begin
		if (rrstn) begin
			if (check_pending) begin
				check("rdata", rdata, last_read);
				check_pending = 1'b0;
			end
			if (rinc && !rempty) begin
				if (model.size() == 0) begin
					errors++;
					$display("a read was accepted at %0t while no word was expected", $time);
				end else begin
					last_read     = model.pop_front();
					check_pending = 1'b1;
					reads_seen++;
				end
			end
		end
	end

	// ******************************
	// drivers and waits
	// ******************************

	task automatic apply_reset();
		fork
			begin
				repeat (4) @(posedge wclk);
				wrstn <= 1'b1;
			end
			begin
				repeat (4) @(posedge rclk);
				rrstn <= 1'b1;
			end
		join
		@(negedge rclk);
	endtask

	task automatic write_words(input int count);
		for (int i = 0; i < count; i++) begin
			@(posedge wclk);
			wr_state = lcg_step(wr_state);
			winc  <= 1'b1;
			wdata <= wr_state[31:24];
		end
		@(posedge wclk);
		winc <= 1'b0;
	endtask

	task automatic wait_not_empty();
		bit seen;
		seen = 1'b0;
		for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
			@(negedge rclk);
			seen = !rempty;
		end
		if (!seen) begin
			errors++;
			$display("timed out waiting for rempty to fall at %0t", $time);
		end
	endtask

	task automatic wait_wr_level_zero();
		bit seen;
		seen = 1'b0;
		for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
			@(negedge wclk);
			seen = (wr_level == 0);
		end
		if (!seen) begin
			errors++;
			$display("timed out waiting for the write level to reach zero at %0t", $time);
		end
	endtask

	// keeps reading until the DUT is empty and no word is left in the model
	task automatic drain();
		bit done;
		done = 1'b0;
		for (int n = 0; n < DRAIN_LIMIT && !done; n++) begin
			@(posedge rclk);
			rinc <= 1'b1;
			@(negedge rclk);
			done = rempty && (model.size() == 0);
		end
		@(posedge rclk);
		rinc <= 1'b0;
		@(negedge rclk);
		if (!done) begin
			errors++;
			$display("drain timed out with %0d words still expected", model.size());
		end
	endtask

	// ******************************
	// tests
	// ******************************

	task automatic reset_state();
		check("wfull", wfull, 1'b0);
		check("rempty", rempty, 1'b1);
		check("wr_level", wr_level, 0);
		check("rd_level", rd_level, 0);
		check("rdata", rdata, 0);
		report_test("reset_state");
	endtask

	task automatic ordered_transfer();
		int base_reads;
		base_reads = reads_seen;
		write_words(5);
		wait_not_empty();
		drain();
		check("reads", reads_seen - base_reads, 5);
		check("rempty", rempty, 1'b1);
		check("rd_level", rd_level, 0);
		report_test("ordered_transfer");
	endtask

	task automatic fill_and_overflow();
		int base_reads;
		int base_writes;
		base_reads  = reads_seen;
		base_writes = writes_seen;
		wait_wr_level_zero();
		// edge i sees the state left by the writes at edges 1 to i-1
		for (int i = 0; i <= 20; i++) begin
			@(posedge wclk);
			if (i >= 1) begin
				check("wfull", wfull, i > 16);
				check("wr_level", wr_level, (i - 1 > 16) ? 16 : i - 1);
			end
			wr_state = lcg_step(wr_state);
			winc  <= (i < 20);
			wdata <= wr_state[31:24];
		end
		@(negedge wclk);
		check("writes", writes_seen - base_writes, 16);
		drain();
		check("reads", reads_seen - base_reads, 16);
		report_test("fill_and_overflow");
	endtask

	task automatic underflow();
		for (int i = 0; i < 6; i++) begin
			@(posedge rclk);
			rinc <= 1'b1;
			@(negedge rclk);
			check("rempty", rempty, 1'b1);
			check("rd_level", rd_level, 0);
			check("rdata", rdata, last_read);
		end
		@(posedge rclk);
		rinc <= 1'b0;
		report_test("underflow");
	endtask

	task automatic random_traffic();
		bit prod_done;
		prod_done = 1'b0;
		fork
			begin
				for (int i = 0; i < TRAFFIC_LEN; i++) begin
					@(posedge wclk);
					wr_state = lcg_step(wr_state);
					winc  <= (wr_state[31:30] != 2'b00);
					wdata <= wr_state[23:16];
				end
				@(posedge wclk);
				winc <= 1'b0;
				prod_done = 1'b1;
			end
			begin
				for (int k = 0; k < 4 * TRAFFIC_LEN && !prod_done; k++) begin
					@(posedge rclk);
					rd_state = lcg_step(rd_state);
					rinc <= rd_state[31];
				end
				if (!prod_done) begin
					errors++;
					$display("the producer did not finish in time");
				end
			end
		join
		drain();
		check("model_size", model.size(), 0);
		report_test("random_traffic");
	endtask

	// ******************************
	// main sequence
	// ******************************

	initial begin
		wclk          = 1'b0;
		rclk          = 1'b0;
		wrstn         = 1'b0;
		rrstn         = 1'b0;
		winc          = 1'b0;
		wdata         = '0;
		rinc          = 1'b0;
		last_read     = '0;
		check_pending = 1'b0;
		wr_state      = SEED;
		rd_state      = ~SEED;
		errors        = 0;
		checks        = 0;
		tests_run     = 0;
		writes_seen   = 0;
		reads_seen    = 0;

		apply_reset();
		reset_state();
		ordered_transfer();
		fill_and_overflow();
		underflow();
		random_traffic();

		errors = errors + DUT.u_properties.fail_count;
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- hw/afifo_dpram.sv
module afifo_dpram (
	input logic      rrstn,
	afifo_ram_if.mem ram
);

	logic [afifo_pkg::DATA_W-1:0] store [afifo_pkg::FIFO_DEPTH];

	// ******************************
	// write side
	// ******************************

	always_ff @(posedge ram.wclk) begin
		if (ram.wen) begin
			store[ram.waddr] <= ram.wdata;
		end
	end

	// ******************************
	// read side
	// ******************************

	// the output register only loads on an accepted read
	// so the last word stays visible while the consumer is idle
	always_ff @(posedge ram.rclk or negedge rrstn) begin
		if (!rrstn) begin
			ram.rdata <= '0;
		end else if (ram.ren) begin
			ram.rdata <= store[ram.raddr];
		end
	end

endmodule

//--- hw/afifo_pkg.sv
package afifo_pkg;

	// ******************************
	// sizes
	// ******************************

	localparam int FIFO_DEPTH = 16;
	localparam int DATA_W     = 8;
	localparam int ADDR_W     = $clog2(FIFO_DEPTH);
	localparam int PTR_W      = ADDR_W + 1; // the extra wrap bit tells full from empty

	// ******************************
	// gray code helpers
	// ******************************

	// reflected gray code where exactly one bit changes per increment
	function automatic logic [PTR_W-1:0] bin2gray(input logic [PTR_W-1:0] bin);
		return bin ^ (bin >> 1);
	endfunction

	// each binary bit is the xor of all gray bits at or above it
	function automatic logic [PTR_W-1:0] gray2bin(input logic [PTR_W-1:0] gray);
		logic [PTR_W-1:0] bin;

		bin[PTR_W-1] = gray[PTR_W-1];
		for (int i = PTR_W - 2; i >= 0; i--) begin
			bin[i] = bin[i+1] ^ gray[i];
		end
		return bin;
	endfunction

endpackage

//--- hw/afifo_ram_if.sv
interface afifo_ram_if;

	// write port, all in the wclk domain
	logic                         wclk;
	logic                         wen;
	logic [afifo_pkg::ADDR_W-1:0] waddr;
	logic [afifo_pkg::DATA_W-1:0] wdata;

	// read port, all in the rclk domain
	logic                         rclk;
	logic                         ren;
	logic [afifo_pkg::ADDR_W-1:0] raddr;
	logic [afifo_pkg::DATA_W-1:0] rdata;

	// the storage array sees both ports and only drives the read data
	modport mem (
		input  wclk,
		input  wen,
		input  waddr,
		input  wdata,
		input  rclk,
		input  ren,
		input  raddr,
		output rdata
	);

	modport wr (
		output wen,
		output waddr
	);

	modport rd (
		output ren,
		output raddr
	);

endinterface

//--- hw/afifo_rd_ctrl.sv
module afifo_rd_ctrl (
	input  logic                        rclk,
	input  logic                        rrstn,
	input  logic                        rinc,
	input  logic [afifo_pkg::PTR_W-1:0] wr_gray,
	output logic [afifo_pkg::PTR_W-1:0] rd_gray,
	output logic                        rempty,
	output logic [afifo_pkg::PTR_W-1:0] rd_level,
	afifo_ram_if.rd                     ram
);

	logic [afifo_pkg::PTR_W-1:0] rd_bin;
	logic [afifo_pkg::PTR_W-1:0] rd_bin_next;
	logic [afifo_pkg::PTR_W-1:0] wr_gray_meta;
	logic [afifo_pkg::PTR_W-1:0] wr_gray_sync;
	logic [afifo_pkg::PTR_W-1:0] wr_bin_sync;
	logic                        rd_accept;

	// ******************************
	// read pointer
	// ******************************

	assign rd_accept   = rinc & ~rempty; // reading an empty FIFO has no effect
	assign rd_bin_next = rd_bin + 1'b1;

	// binary and gray advance together so rempty is exact after each read
	always_ff @(posedge rclk or negedge rrstn) begin
		if (!rrstn) begin
			rd_bin  <= '0;
			rd_gray <= '0;
		end else if (rd_accept) begin
			rd_bin  <= rd_bin_next;
			rd_gray <= afifo_pkg::bin2gray(rd_bin_next);
		end
	end

	// ******************************
	// write pointer synchronizer
	// ******************************

	// a new write shows up here two to three rclk edges after it was accepted
	always_ff @(posedge rclk or negedge rrstn) begin
		if (!rrstn) begin
			wr_gray_meta <= '0;
			wr_gray_sync <= '0;
		end else begin
			wr_gray_meta <= wr_gray;
			wr_gray_sync <= wr_gray_meta;
		end
	end

	// ******************************
	// empty flag and level
	// ******************************

	// equal pointers including the wrap bit mean nothing is left to read
	assign rempty = (rd_gray == wr_gray_sync);

	// writes are only counted once they have crossed over,
	// so this level never overcounts
	assign wr_bin_sync = afifo_pkg::gray2bin(wr_gray_sync);
	assign rd_level    = wr_bin_sync - rd_bin;

	// ******************************
	// ram read port
	// ******************************

	// the ram registers the word, so rdata follows one rclk after the accept
	assign ram.ren   = rd_accept;
	assign ram.raddr = rd_bin[afifo_pkg::ADDR_W-1:0];

endmodule

//--- hw/afifo_top.sv
module afifo_top (
	input  logic                         wclk,
	input  logic                         wrstn,
	input  logic                         winc,
	input  logic [afifo_pkg::DATA_W-1:0] wdata,
	input  logic                         rclk,
	input  logic                         rrstn,
	input  logic                         rinc,
	output logic                         wfull,
	output logic [afifo_pkg::PTR_W-1:0]  wr_level,
	output logic                         rempty,
	output logic [afifo_pkg::PTR_W-1:0]  rd_level,
	output logic [afifo_pkg::DATA_W-1:0] rdata
);

	// gray pointers crossing between the two clock domains
	logic [afifo_pkg::PTR_W-1:0] wr_gray;
	logic [afifo_pkg::PTR_W-1:0] rd_gray;

	afifo_ram_if ram_bus ();

	// ******************************
	// ram port wiring
	// ******************************

	assign ram_bus.wclk  = wclk;
	assign ram_bus.wdata = wdata; // data goes to the array untouched
	assign ram_bus.rclk  = rclk;
	assign rdata         = ram_bus.rdata;

	// ******************************
	// storage
	// ******************************

	afifo_dpram u_dpram (
		.rrstn (rrstn),
		.ram   (ram_bus.mem)
	);

	// ******************************
	// write domain
	// ******************************

	afifo_wr_ctrl u_wr_ctrl (
		.wclk     (wclk),
		.wrstn    (wrstn),
		.winc     (winc),
		.rd_gray  (rd_gray),
		.wr_gray  (wr_gray),
		.wfull    (wfull),
		.wr_level (wr_level),
		.ram      (ram_bus.wr)
	);

	// ******************************
	// read domain
	// ******************************

	afifo_rd_ctrl u_rd_ctrl (
		.rclk     (rclk),
		.rrstn    (rrstn),
		.rinc     (rinc),
		.wr_gray  (wr_gray),
		.rd_gray  (rd_gray),
		.rempty   (rempty),
		.rd_level (rd_level),
		.ram      (ram_bus.rd)
	);

endmodule

//--- hw/afifo_wr_ctrl.sv
module afifo_wr_ctrl (
	input  logic                        wclk,
	input  logic                        wrstn,
	input  logic                        winc,
	input  logic [afifo_pkg::PTR_W-1:0] rd_gray,
	output logic [afifo_pkg::PTR_W-1:0] wr_gray,
	output logic                        wfull,
	output logic [afifo_pkg::PTR_W-1:0] wr_level,
	afifo_ram_if.wr                     ram
);

	logic [afifo_pkg::PTR_W-1:0] wr_bin;
	logic [afifo_pkg::PTR_W-1:0] wr_bin_next;
	logic [afifo_pkg::PTR_W-1:0] rd_gray_meta;
	logic [afifo_pkg::PTR_W-1:0] rd_gray_sync;
	logic [afifo_pkg::PTR_W-1:0] rd_bin_sync;
	logic [afifo_pkg::PTR_W-1:0] full_match;
	logic                        wr_accept;

	// ******************************
	// write pointer
	// ******************************

	assign wr_accept   = winc & ~wfull; // a request against a full FIFO is dropped
	assign wr_bin_next = wr_bin + 1'b1;

	// the gray copy moves in the same cycle as the binary pointer
	// so wfull never trails a back to back write
	always_ff @(posedge wclk or negedge wrstn) begin
		if (!wrstn) begin
			wr_bin  <= '0;
			wr_gray <= '0;
		end else if (wr_accept) begin
			wr_bin  <= wr_bin_next;
			wr_gray <= afifo_pkg::bin2gray(wr_bin_next);
		end
	end

	// ******************************
	// read pointer synchronizer
	// ******************************

	// rd_gray comes straight from a register in the rclk domain
	// and only one bit changes per step, so two flops are enough
	always_ff @(posedge wclk or negedge wrstn) begin
		if (!wrstn) begin
			rd_gray_meta <= '0;
			rd_gray_sync <= '0;
		end else begin
			rd_gray_meta <= rd_gray;
			rd_gray_sync <= rd_gray_meta;
		end
	end

	// ******************************
	// full flag and level
	// ******************************

	// in gray code a pointer one lap ahead differs only in the top two bits
	assign full_match = {~rd_gray_sync[afifo_pkg::PTR_W-1 -: 2],
		rd_gray_sync[afifo_pkg::PTR_W-3:0]};
	assign wfull = (wr_gray == full_match);

	// the synchronized read pointer lags, so this level never undercounts
	assign rd_bin_sync = afifo_pkg::gray2bin(rd_gray_sync);
	assign wr_level    = wr_bin - rd_bin_sync;

	// ******************************
	// ram write port
	// ******************************

	assign ram.wen   = wr_accept;
	assign ram.waddr = wr_bin[afifo_pkg::ADDR_W-1:0]; // the wrap bit is not an address bit

endmodule
